// ==== rtl/ines_flags.sv ====
// Header decode into the mapper flags word
// Also gives the PRG and CHR byte counts for the loader

`include "nes_defines.svh"

module ines_flags (
	input  nes_pkg::byte_t [`NES_HDR_LEN-1:0] header,
	input  logic                              invert_mirroring,
	output nes_pkg::mapper_flags_t            mapper_flags,
	output nes_pkg::load_count_t              prg_bytes,
	output nes_pkg::load_count_t              chr_bytes
);

	nes_pkg::byte_t prg_pages;
	nes_pkg::byte_t chr_pages;
	logic           is_nes20;
	logic           is_dirty;
	logic           tail_nonzero;

	// Smallest k with pages <= 2**k, limited to 7
	function automatic nes_pkg::size_code_t size_code(input nes_pkg::byte_t pages);
		nes_pkg::size_code_t code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if ({1'b0, pages} <= (9'd1 << k))
				code = 3'(k);
		end
		return code;
	endfunction

	assign prg_pages = header[4];
	assign chr_pages = header[5];

	assign is_nes20 = (header[7][3:2] == 2'b10);

	always_comb begin
		tail_nonzero = (header[9][7:1] != '0);
		for (int i = 10; i < `NES_HDR_LEN; i++)
			tail_nonzero = tail_nonzero | (header[i] != '0);
	end

	// Old dumps often carry junk in the tail bytes
	assign is_dirty = !is_nes20 && tail_nonzero;

	always_comb begin
		mapper_flags                = '0;
		mapper_flags.mapper[3:0]    = header[6][7:4];
		mapper_flags.mapper[7:4]    = is_dirty ? 4'h0 : header[7][7:4];
		mapper_flags.prg_size       = size_code(prg_pages);
		mapper_flags.chr_size       = size_code(chr_pages);
		mapper_flags.mirroring      = header[6][0] ^ invert_mirroring;
		mapper_flags.has_chr_ram    = (chr_pages == '0);
		mapper_flags.four_screen    = header[6][3];
		mapper_flags.has_saves      = header[6][1];   // Battery backed RAM
		if (is_nes20) begin
			mapper_flags.submapper_byte = header[8];
			mapper_flags.prg_ram_shift  = header[10][3:0];
		end
	end

	assign prg_bytes = nes_pkg::load_count_t'(prg_pages) << `NES_PRG_PAGE_SHIFT;
	assign chr_bytes = nes_pkg::load_count_t'(chr_pages) << `NES_CHR_PAGE_SHIFT;

endmodule

// ==== rtl/ines_loader.sv ====
// Cartridge image loader
// Captures the 16-byte header, checks it, then streams PRG and CHR
// bytes out as memory writes

`include "nes_defines.svh"

module ines_loader (
	input  logic                   clk,
	input  logic                   reset_nes,
	input  logic                   load_start,
	input  nes_pkg::byte_t         byte_in,
	input  logic                   byte_strobe,
	input  logic                   invert_mirroring,
	output nes_pkg::mem_write_t    mem_wr,
	output nes_pkg::mapper_flags_t mapper_flags,
	output logic                   busy,
	output logic                   done,
	output logic                   error
);

	localparam int IDX_BITS = $clog2(`NES_HDR_LEN);
	localparam int CNT_BITS = IDX_BITS + 1;

	nes_pkg::loader_state_e            state;
	nes_pkg::byte_t [`NES_HDR_LEN-1:0] header_q;
	logic [CNT_BITS-1:0]               hdr_count;
	nes_pkg::rom_addr_t                addr_q;
	nes_pkg::load_count_t              bytes_left;
	nes_pkg::load_count_t              prg_bytes;
	nes_pkg::load_count_t              chr_bytes;
	logic                              header_full;
	logic                              header_ok;
	logic                              loading;
	logic                              take_byte;

	ines_flags flags_i (
		.header           (header_q),
		.invert_mirroring (invert_mirroring),
		.mapper_flags     (mapper_flags),
		.prg_bytes        (prg_bytes),
		.chr_bytes        (chr_bytes)
	);

	assign header_full = (hdr_count == CNT_BITS'(`NES_HDR_LEN));

	// Signature check, trainers are not supported
	assign header_ok = (header_q[0] == `NES_MAGIC_0) && (header_q[1] == `NES_MAGIC_1) &&
		(header_q[2] == `NES_MAGIC_2) && (header_q[3] == `NES_MAGIC_3) && !header_q[6][2];

	assign loading   = (state == nes_pkg::LOAD_PRG) || (state == nes_pkg::LOAD_CHR);
	assign take_byte = loading && byte_strobe && (bytes_left != '0);

	assign mem_wr = '{write: take_byte, addr: addr_q, data: byte_in};

	//////////////////////////////////////////////////////////////////////
	// Header store
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if ((state == nes_pkg::HEADER) && byte_strobe && !header_full)
			header_q[hdr_count[IDX_BITS-1:0]] <= byte_in;
	end

	//////////////////////////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes || load_start) begin
			state     <= nes_pkg::HEADER;
			hdr_count <= '0;
			busy      <= 1'b0;
			done      <= 1'b0;
			error     <= 1'b0;
		end else begin
			case (state)
				nes_pkg::HEADER: begin
					if (header_full) begin
						if (header_ok) begin
							busy  <= 1'b1;
							state <= nes_pkg::LOAD_PRG;
						end else begin
							state <= nes_pkg::ERROR;
						end
					end else if (byte_strobe) begin
						hdr_count <= hdr_count + 1'b1;
					end
				end
				nes_pkg::LOAD_PRG: begin
					if (bytes_left == '0)
						state <= nes_pkg::LOAD_CHR;
				end
				nes_pkg::LOAD_CHR: begin
					if (bytes_left == '0) begin
						done  <= 1'b1;
						busy  <= 1'b0;
						state <= nes_pkg::DONE;
					end
				end
				nes_pkg::ERROR: begin
					done  <= 1'b1;
					error <= 1'b1;
				end
				default: done <= 1'b1;   // DONE holds
			endcase
		end
	end

	// Address and remaining count, loaded on each section start
	always_ff @(posedge clk) begin
		if ((state == nes_pkg::HEADER) && header_full) begin
			addr_q     <= '0;
			bytes_left <= prg_bytes;
		end else if ((state == nes_pkg::LOAD_PRG) && (bytes_left == '0)) begin
			addr_q     <= `NES_CHR_BASE;
			bytes_left <= chr_bytes;
		end else if (take_byte) begin
			addr_q     <= addr_q + 1'b1;
			bytes_left <= bytes_left - 1'b1;
		end
	end

	// Address plus bytes left always lands on the section end
	a_write_in_section: assert property (@(posedge clk) disable iff (reset_nes)
		mem_wr.write |-> loading && (addr_q + bytes_left ==
			((state == nes_pkg::LOAD_PRG) ? prg_bytes : `NES_CHR_BASE + chr_bytes)));

	a_busy_tracks_state: assert property (@(posedge clk) disable iff (reset_nes || load_start)
		busy == loading);

endmodule

// ==== rtl/joypad_mapper.sv ====
// Builds the load word for each controller port
// Host to NES button order, pad swap and multitap signature

`include "nes_defines.svh"

module joypad_mapper (
	input  nes_pkg::host_pad_t [`NES_NUM_PADS-1:0]  pads,
	input  logic                                    pad_swap,
	input  logic                                    multitap,
	output nes_pkg::pad_word_t [`NES_NUM_PORTS-1:0] words
);

	nes_pkg::pad_buttons_t [`NES_NUM_PADS-1:0] nes_pads;

	// Host sends directions low, buttons high
	function automatic nes_pkg::pad_buttons_t reorder(input nes_pkg::host_pad_t h);
		return {h[0], h[1], h[2], h[3], h[7], h[6], h[5], h[4]};
	endfunction

	always_comb begin
		for (int i = 0; i < `NES_NUM_PADS; i++)
			nes_pads[i] = reorder(pads[i]);
	end

	//////////////////////////////////////////////////////////////////////
	// Port words
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int p = 0; p < `NES_NUM_PORTS; p++) begin
			words[p][7:0] = pad_swap ? nes_pads[p ^ 1] : nes_pads[p];
			if (multitap) begin
				words[p][23:16] = (p == 0) ? `NES_TAP_SIG_P1 : `NES_TAP_SIG_P2;
				words[p][15:8]  = nes_pads[p + 2];   // Pads 3 and 4 behind the tap
			end else begin
				words[p][23:8] = 16'hFFFF;           // Open bus reads as 1
			end
		end
	end

endmodule

// ==== rtl/joypad_shifter.sv ====
// One controller port
// Parallel load on strobe, shift right on the falling joypad clock

`include "nes_defines.svh"

module joypad_shifter #(
	parameter int width = `NES_PAD_WORD_BITS
) (
	input  logic               clk,
	input  logic               reset_nes,
	input  nes_pkg::pad_word_t load_word,
	input  logic               strobe,
	input  logic               pad_clock,
	output logic               data_bit
);

	logic [width-1:0] shift_q;
	logic             clock_q;      // Previous clock level
	logic             clock_fall;

	assign clock_fall = clock_q && !pad_clock;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			shift_q <= '0;
			clock_q <= 1'b0;
		end else begin
			clock_q <= pad_clock;
			if (strobe)
				shift_q <= width'(load_word);   // Load wins over a shift
			else if (clock_fall)
				shift_q <= {1'b0, shift_q[width-1:1]};
		end
	end

	assign data_bit = shift_q[0];

	// Empty port stays empty until a load
	a_zero_until_load: assert property (@(posedge clk) disable iff (reset_nes)
		(shift_q == '0) && !strobe |=> (shift_q == '0));

endmodule

// ==== rtl/nes_defines.svh ====
// Constants for the cartridge loader and the controller ports
// Header layout, memory map and pad shift words

`ifndef NES_DEFINES_SVH
`define NES_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// iNES header
//////////////////////////////////////////////////////////////////////

`define NES_HDR_LEN        16
`define NES_MAGIC_0        8'h4E   // N
`define NES_MAGIC_1        8'h45   // E
`define NES_MAGIC_2        8'h53   // S
`define NES_MAGIC_3        8'h1A

// Page sizes as shifts, 16 KB PRG and 8 KB CHR
`define NES_PRG_PAGE_SHIFT 14
`define NES_CHR_PAGE_SHIFT 13
`define NES_CHR_BASE       22'h200000

//////////////////////////////////////////////////////////////////////
// Controller ports
//////////////////////////////////////////////////////////////////////

`define NES_PAD_WORD_BITS  24
`define NES_NUM_PORTS      2
`define NES_NUM_PADS       4
`define NES_TAP_SIG_P1     8'h08
`define NES_TAP_SIG_P2     8'h04

`endif

// ==== rtl/nes_front_end.sv ====
// Top of the cartridge loader and the two joypad ports
// Loader, pad word mapper and one shifter per port

`include "nes_defines.svh"

module nes_front_end (
	input  logic                                   clk,
	input  logic                                   reset_nes,
	// Cartridge image stream
	input  logic                                   load_start,
	input  nes_pkg::byte_t                         byte_in,
	input  logic                                   byte_strobe,
	input  logic                                   invert_mirroring,
	// Controllers
	input  nes_pkg::host_pad_t [`NES_NUM_PADS-1:0] pads,
	input  logic                                   pad_swap,
	input  logic                                   multitap,
	input  nes_pkg::pad_bus_t                      pad_bus,
	// Results
	output nes_pkg::mem_write_t                    mem_wr,
	output nes_pkg::mapper_flags_t                 mapper_flags,
	output logic                                   busy,
	output logic                                   done,
	output logic                                   error,
	output logic [`NES_NUM_PORTS-1:0]              pad_data
);

	nes_pkg::pad_word_t [`NES_NUM_PORTS-1:0] port_words;

	//////////////////////////////////////////////////////////////////////
	// Loader
	//////////////////////////////////////////////////////////////////////

	ines_loader loader_i (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.load_start       (load_start),
		.byte_in          (byte_in),
		.byte_strobe      (byte_strobe),
		.invert_mirroring (invert_mirroring),
		.mem_wr           (mem_wr),
		.mapper_flags     (mapper_flags),
		.busy             (busy),
		.done             (done),
		.error            (error)
	);

	//////////////////////////////////////////////////////////////////////
	// Joypad ports
	//////////////////////////////////////////////////////////////////////

	joypad_mapper mapper_i (
		.pads     (pads),
		.pad_swap (pad_swap),
		.multitap (multitap),
		.words    (port_words)
	);

	// Each port has its own clock, strobe is shared
	for (genvar i = 0; i < `NES_NUM_PORTS; i++) begin : g_port
		joypad_shifter #(
			.width (`NES_PAD_WORD_BITS)
		) shifter_i (
			.clk       (clk),
			.reset_nes (reset_nes),
			.load_word (port_words[i]),
			.strobe    (pad_bus.strobe),
			.pad_clock (pad_bus.clock[i]),
			.data_bit  (pad_data[i])
		);
	end

endmodule

// ==== rtl/nes_pkg.sv ====
// Shared types for the loader and the joypad ports
// Memory write bus, mapper flags word, pad words and loader states

`include "nes_defines.svh"

package nes_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [21:0] rom_addr_t;
	typedef logic [21:0] load_count_t;     // Bytes still to load
	typedef logic [2:0]  size_code_t;      // log2 of page count, capped

	// Flags word handed to the mapper logic
	typedef struct packed {
		logic [1:0]  spare;
		logic [3:0]  prg_ram_shift;    // NES 2.0 only
		logic        has_saves;
		byte_t       submapper_byte;   // NES 2.0 only
		logic        four_screen;
		logic        has_chr_ram;
		logic        mirroring;
		size_code_t  chr_size;
		size_code_t  prg_size;
		byte_t       mapper;
	} mapper_flags_t;

	typedef struct packed {
		logic      write;
		rom_addr_t addr;
		byte_t     data;
	} mem_write_t;

	// NES order from bit 0: A B Select Start Up Down Left Right
	typedef logic [7:0] pad_buttons_t;
	typedef logic [7:0] host_pad_t;
	typedef logic [`NES_PAD_WORD_BITS-1:0] pad_word_t;

	typedef struct packed {
		logic                      strobe;
		logic [`NES_NUM_PORTS-1:0] clock;   // One per port
	} pad_bus_t;

	typedef enum logic [2:0] {
		HEADER,
		LOAD_PRG,
		LOAD_CHR,
		ERROR,
		DONE
	} loader_state_e;

endpackage

// ==== verif/loader_stimulus.txt ====
// Loader and joypad test records, 20 hex words each, a lone 00 ends the list
// Kind 01, header case:
//   01 invert_mirroring h0 .. h15 expected_error expected_flags
// Kind 02, pad case with opts bit 0 pad_swap and bit 1 multitap:
//   02 opts pad1 pad2 pad3 pad4 port1_word port2_word, then twelve zero words

// 1 PRG and 1 CHR page, mapper 1, vertical mirroring
01 0 4E 45 53 1A 01 01 11 00 00 00 00 00 00 00 00 00 0 00004001

// NES 2.0, submapper byte 15, PRG RAM shift 7, battery, mirroring inverted
01 1 4E 45 53 1A 02 01 43 08 15 00 07 00 00 00 00 00 0 1E2A0104

// Dirty iNES 1.0 with text in the tail, high mapper nibble dropped
01 0 4E 45 53 1A 01 02 21 40 33 00 44 69 73 6B 44 75 0 00004802

// Clean header, mapper 41, CHR RAM, four screen, PAL bit in byte 9
01 1 4E 45 53 1A 03 00 18 40 00 01 00 00 00 00 00 00 0 0001C241

// Dirty through byte 9 upper bits, invert on with mirroring bit clear
01 1 4E 45 53 1A 01 01 B0 10 00 02 00 00 00 00 00 00 0 0000400B

// NES 2.0 with CHR RAM and PRG RAM shift A
01 0 4E 45 53 1A 01 00 02 28 F0 00 0A 07 00 00 00 00 0 2BE08020

// Broken signature
01 0 4E 45 53 00 01 01 00 00 00 00 00 00 00 00 00 00 1 00000000

// Trainer present
01 0 4E 45 53 1A 01 01 04 00 00 00 00 00 00 00 00 00 1 00000000

// Two pads, no swap, no multitap
02 0 1E A4 6D C2 FFFF71 FFFF2A 0 0 0 0 0 0 0 0 0 0 0 0

// Pads 1 and 2 swapped
02 1 1E A4 6D C2 FFFF2A FFFF71 0 0 0 0 0 0 0 0 0 0 0 0

// Multitap, pads 3 and 4 behind the signature
02 2 1E A4 6D C2 08B671 044C2A 0 0 0 0 0 0 0 0 0 0 0 0

// Multitap with swap
02 3 1E A4 6D C2 08B62A 044C71 0 0 0 0 0 0 0 0 0 0 0 0

// Multitap, all pressed and single buttons
02 2 FF 00 01 80 0880FF 040800 0 0 0 0 0 0 0 0 0 0 0 0

00

// ==== verif/nes_front_end_tb.sv ====
// Testbench for the cartridge loader and the joypad ports
// Header and pad records come from the stimulus file, payload from an xorshift

`include "nes_defines.svh"

module nes_front_end_tb;

	localparam int REC_WORDS  = 20;
	localparam int STIM_WORDS = 512;
	localparam int PRG_PAGE   = 1 << `NES_PRG_PAGE_SHIFT;
	localparam int CHR_PAGE   = 1 << `NES_CHR_PAGE_SHIFT;

	logic                                   clk;
	logic                                   reset_nes;
	logic                                   load_start;
	nes_pkg::byte_t                         byte_in;
	logic                                   byte_strobe;
	logic                                   invert_mirroring;
	nes_pkg::host_pad_t [`NES_NUM_PADS-1:0] pads;
	logic                                   pad_swap;
	logic                                   multitap;
	nes_pkg::pad_bus_t                      pad_bus;
	nes_pkg::mem_write_t                    mem_wr;
	nes_pkg::mapper_flags_t                 mapper_flags;
	logic                                   busy;
	logic                                   done;
	logic                                   error;
	logic [`NES_NUM_PORTS-1:0]              pad_data;

	logic [31:0]    stim [0:STIM_WORDS-1];
	nes_pkg::byte_t hdr [0:`NES_HDR_LEN-1];   // Header of the current record
	logic [31:0]    rng;
	int             write_count;
	int             limit_cycles;

	nes_front_end dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Every memory write the loader issues
	always @(posedge clk)
		if (!reset_nes && mem_wr.write === 1'b1)
			write_count++;

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("ERROR: watchdog expired after %0d cycles", limit_cycles);
		stop_run();
	end

	//////////////////////////////////////////////////////////////////////
	// Reporting
	//////////////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic fail_with(input string why);
		$display("ERROR: %s", why);
		stop_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
			stop_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Models
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic nes_pkg::size_code_t size_code_model(input nes_pkg::byte_t pages);
		int k;
		k = 0;
		while (k < 7 && (1 << k) < pages)
			k++;
		return nes_pkg::size_code_t'(k);
	endfunction

	function automatic nes_pkg::mapper_flags_t flags_model(input logic inv);
		nes_pkg::mapper_flags_t f;
		logic                   nes20;
		logic                   dirty;
		f     = '0;
		nes20 = (hdr[7][3:2] == 2'b10);
		dirty = !nes20 && (hdr[9][7:1] != 0);
		for (int i = 10; i < `NES_HDR_LEN; i++)
			dirty = dirty || (!nes20 && hdr[i] != 0);
		f.mapper      = {dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
		f.prg_size    = size_code_model(hdr[4]);
		f.chr_size    = size_code_model(hdr[5]);
		f.has_chr_ram = (hdr[5] == 0);
		f.mirroring   = hdr[6][0] ^ inv;
		f.four_screen = hdr[6][3];
		f.has_saves   = hdr[6][1];
		if (nes20) begin
			f.submapper_byte = hdr[8];
			f.prg_ram_shift  = hdr[10][3:0];
		end
		return f;
	endfunction

	function automatic nes_pkg::pad_buttons_t nes_order(input nes_pkg::host_pad_t h);
		int                    src [8] = '{4, 5, 6, 7, 3, 2, 1, 0};   // Host bit per NES bit
		nes_pkg::pad_buttons_t b;
		for (int i = 0; i < 8; i++)
			b[i] = h[src[i]];
		return b;
	endfunction

	function automatic nes_pkg::pad_word_t port_word_model(input int p);
		nes_pkg::byte_t low;
		nes_pkg::byte_t sig;
		low = pad_swap ? nes_order(pads[1 - p]) : nes_order(pads[p]);
		sig = (p == 0) ? `NES_TAP_SIG_P1 : `NES_TAP_SIG_P2;
		if (multitap)
			return {sig, nes_order(pads[p + 2]), low};
		return {16'hFFFF, low};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Test sequences
	//////////////////////////////////////////////////////////////////////

	task automatic run_cart_record(input int base);
		logic                   inv;
		logic                   exp_err;
		int                     prg_total;
		int                     total;
		int                     pulses;
		int                     stalls;
		int                     start_count;
		nes_pkg::byte_t         data;
		nes_pkg::rom_addr_t     exp_addr;
		nes_pkg::mapper_flags_t model;
		inv     = stim[base + 1][0];
		exp_err = stim[base + 18][0];
		for (int i = 0; i < `NES_HDR_LEN; i++)
			hdr[i] = stim[base + 2 + i][7:0];
		prg_total = hdr[4] * PRG_PAGE;
		total     = prg_total + hdr[5] * CHR_PAGE;
		@(negedge clk);
		invert_mirroring = inv;
		load_start       = 1'b1;
		byte_strobe      = 1'b0;
		@(negedge clk);
		load_start = 1'b0;
		#1;
		check_value("done", done, 1'b0);
		start_count = write_count;
		for (int i = 0; i < `NES_HDR_LEN; i++) begin
			@(negedge clk);
			byte_strobe = 1'b1;
			byte_in     = hdr[i];
		end
		// Junk strobes only on a bad image, which must never write
		stalls = 0;
		do begin
			@(negedge clk);
			byte_strobe = exp_err;
			byte_in     = 8'hA5;
			#1;
			check_value("mem_wr.write", mem_wr.write, 1'b0);
			stalls++;
			if (stalls > 16)
				fail_with("loader did not leave the header state");
		end while (!(exp_err ? done : busy));
		if (exp_err) begin
			check_value("error", error, 1'b1);
			check_value("busy", busy, 1'b0);
			check_value("write pulse count", write_count - start_count, 0);
		end else begin
			pulses = 0;
			stalls = 0;
			rng    = xorshift32(rng);
			data   = rng[7:0];
			while (pulses < total) begin
				@(negedge clk);
				byte_strobe = 1'b1;
				byte_in     = data;
				#1;
				if (mem_wr.write) begin
					exp_addr = (pulses < prg_total) ? pulses : `NES_CHR_BASE + pulses - prg_total;
					check_value("mem_wr.addr", mem_wr.addr, exp_addr);
					check_value("mem_wr.data", mem_wr.data, data);
					pulses++;
					stalls = 0;
					rng    = xorshift32(rng);
					data   = rng[7:0];
				end else begin
					stalls++;   // One lost strobe at the PRG to CHR switch
					if (stalls > 4)
						fail_with("loader stopped taking payload bytes");
				end
			end
			stalls = 0;
			do begin
				@(negedge clk);
				byte_strobe = 1'b0;
				#1;
				stalls++;
				if (stalls > 8)
					fail_with("done did not rise after the last payload byte");
			end while (!done);
			model = flags_model(inv);
			check_value("busy", busy, 1'b0);
			check_value("error", error, 1'b0);
			check_value("write pulse count", write_count - start_count, total);
			check_value("flags in stimulus file", stim[base + 19], model);
			check_value("mapper_flags", mapper_flags, model);
		end
	endtask

	task automatic shift_port(input int p, input nes_pkg::pad_word_t word,
		input logic other_bit);
		string name;
		string other_name;
		name       = $sformatf("pad_data[%0d]", p);
		other_name = $sformatf("pad_data[%0d]", 1 - p);
		for (int k = 0; k < `NES_PAD_WORD_BITS; k++) begin
			check_value(name, pad_data[p], word[k]);
			check_value(other_name, pad_data[1 - p], other_bit);
			@(negedge clk);
			pad_bus.clock[p] = 1'b1;
			@(negedge clk);
			pad_bus.clock[p] = 1'b0;
			@(negedge clk);
			#1;
		end
		check_value(name, pad_data[p], 1'b0);   // Zero fill once drained
	endtask

	task automatic run_pad_record(input int base);
		nes_pkg::pad_word_t expected [`NES_NUM_PORTS];
		@(negedge clk);
		pad_swap = stim[base + 1][0];
		multitap = stim[base + 1][1];
		for (int i = 0; i < `NES_NUM_PADS; i++)
			pads[i] = stim[base + 2 + i][7:0];
		pad_bus.strobe = 1'b1;
		@(negedge clk);
		pad_bus.strobe = 1'b0;
		#1;
		for (int p = 0; p < `NES_NUM_PORTS; p++) begin
			expected[p] = port_word_model(p);
			check_value("port word in stimulus file", stim[base + 6 + p], expected[p]);
		end
		shift_port(0, expected[0], expected[1][0]);
		shift_port(1, expected[1], 1'b0);
	endtask

	initial begin
		int idx;
		int work;
		reset_nes        = 1'b1;
		load_start       = 1'b0;
		byte_in          = '0;
		byte_strobe      = 1'b0;
		invert_mirroring = 1'b0;
		pads             = '0;
		pad_swap         = 1'b0;
		multitap         = 1'b0;
		pad_bus          = '0;
		rng              = 32'h845c;
		write_count      = 0;
		$readmemh("verif/loader_stimulus.txt", stim);
		// Watchdog budget from the bytes and bits in the file
		work = 200;
		for (idx = 0; idx < STIM_WORDS && stim[idx] !== 32'd0; idx += REC_WORDS)
			if (stim[idx] === 32'd1)
				work += 2 * (16 + stim[idx + 6] * PRG_PAGE + stim[idx + 7] * CHR_PAGE) + 100;
			else
				work += 8 * `NES_NUM_PORTS * `NES_PAD_WORD_BITS + 100;
		limit_cycles = work;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_nes = 1'b0;
		#1;
		check_value("pad_data", pad_data, 0);
		check_value("busy", busy, 1'b0);
		check_value("done", done, 1'b0);
		check_value("error", error, 1'b0);
		check_value("mem_wr.write", mem_wr.write, 1'b0);
		idx = 0;
		while (stim[idx] !== 32'd0) begin
			if (stim[idx] === 32'd1)
				run_cart_record(idx);
			else if (stim[idx] === 32'd2)
				run_pad_record(idx);
			else
				fail_with("unknown record kind in the stimulus file");
			idx += REC_WORDS;
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/nes_pkg.sv
rtl/ines_flags.sv
rtl/ines_loader.sv
rtl/joypad_mapper.sv
rtl/joypad_shifter.sv
rtl/nes_front_end.sv
verif/nes_front_end_tb.sv
